/* common/framer_pkg.sv */
package framer_pkg;

    //////////////////////////////////////////////////
    // Sample and word widths
    //////////////////////////////////////////////////

    localparam int SAMPLE_W = 16;

    // One word carries one sample from each channel
    localparam int WORD_W = 2 * SAMPLE_W;

    // Decimation by a power of two, so the average is a shift
    localparam int DECIM_FACTOR = 4;
    localparam int DECIM_SHIFT  = $clog2(DECIM_FACTOR);
    localparam int ACC_W        = SAMPLE_W + DECIM_SHIFT;

    // Frame and word counter
    localparam int FRAME_LEN   = 64;
    localparam int FRAME_CNT_W = 7;

    // Word FIFO
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;

    //////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                       valid;
        logic signed [SAMPLE_W-1:0] data;
    } sample_t;

    typedef struct packed {
        logic              tvalid;
        logic              tlast;
        logic [WORD_W-1:0] tdata;
    } stream_t;

    // Frame FSM states
    typedef enum logic [1:0] {
        IDLE,
        SEND,
        HOLD
    } streamer_state_t;

endpackage

/* hw/channel_decimator.sv */
`timescale 1ns/10ps

module channel_decimator import framer_pkg::*; (
    input  logic    clk,
    input  logic    reset_b,
    input  sample_t sample_in,
    output sample_t dec_out
);

    // Running sum of the current group, wide enough for four samples
    logic signed [ACC_W-1:0]    acc;
    logic signed [ACC_W-1:0]    sample_ext;
    logic signed [ACC_W-1:0]    sum;

    // Position inside the group of four
    logic [DECIM_SHIFT-1:0]     grp_cnt;
    logic                       group_done;

    // Output registers
    logic                       dec_valid;
    logic signed [SAMPLE_W-1:0] dec_data;

    //////////////////////////////////////////////////
    // Accumulate
    //////////////////////////////////////////////////

    // Sign extend the incoming sample to accumulator width
    assign sample_ext = {{DECIM_SHIFT{sample_in.data[SAMPLE_W-1]}}, sample_in.data};

    assign sum = acc + sample_ext;

    // Fourth accepted sample of the group
    assign group_done = sample_in.valid &&
                        (grp_cnt == DECIM_SHIFT'(DECIM_FACTOR - 1));

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            acc     <= '0;
            grp_cnt <= '0;
        end else if (sample_in.valid) begin
            if (group_done) begin
                // Start the next group from zero
                acc     <= '0;
                grp_cnt <= '0;
            end else begin
                acc     <= sum;
                grp_cnt <= grp_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Average output
    //////////////////////////////////////////////////

    // One-cycle strobe after the group closes
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= group_done;
        end
    end

    // Dropping the low bits of a signed sum floors toward minus infinity
    always_ff @(posedge clk) begin
        if (group_done) begin
            dec_data <= sum[ACC_W-1:DECIM_SHIFT];
        end
    end

    assign dec_out.valid = dec_valid;
    assign dec_out.data  = dec_data;

endmodule

/* hw/frame_streamer/word_fifo.sv */
`timescale 1ns/10ps

module word_fifo import framer_pkg::*; (
    input  logic              clk,
    input  logic              reset_b,
    input  logic              wr_en,
    input  logic [WORD_W-1:0] wr_data,
    input  logic              rd_en,
    output logic [WORD_W-1:0] rd_data,
    output logic              empty,
    output logic              overflow
);

    logic [WORD_W-1:0]  mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;

    logic               full;
    logic               do_wr;
    logic               do_rd;

    assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    // A write into a full FIFO is lost
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Head word visible without a read strobe
    assign rd_data = mem[rd_ptr];

    //////////////////////////////////////////////////
    // Pointers, count and overflow flag
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // Sticky until reset
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            overflow <= 1'b0;
        end else if (wr_en && full) begin
            overflow <= 1'b1;
        end
    end

endmodule

/* hw/frame_streamer/frame_streamer.sv */
`timescale 1ns/10ps

module frame_streamer import framer_pkg::*; (
    input  logic    clk,
    input  logic    reset_b,
    input  sample_t dec0,
    input  sample_t dec1,
    input  logic    tready,
    output stream_t stream,
    output logic    frame_active,
    output logic    overflow
);

    // Channel pairing
    logic [SAMPLE_W-1:0]    hold0;
    logic [SAMPLE_W-1:0]    hold1;
    logic                   present0;
    logic                   present1;
    logic                   pair_wr;

    // FIFO read side
    logic [WORD_W-1:0]      fifo_rd_data;
    logic                   fifo_empty;

    // Frame control
    streamer_state_t        state;
    streamer_state_t        next_state;
    logic [FRAME_CNT_W-1:0] beat_cnt;
    logic                   last_beat;
    logic                   tvalid;
    logic                   xfer;

    //////////////////////////////////////////////////
    // Pair the two decimated channels
    //////////////////////////////////////////////////

    // Holding registers carry data only
    always_ff @(posedge clk) begin
        if (dec0.valid) begin
            hold0 <= dec0.data;
        end
        if (dec1.valid) begin
            hold1 <= dec1.data;
        end
    end

    // A fresh sample wins over the clear from a pair write
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            present0 <= 1'b0;
            present1 <= 1'b0;
        end else begin
            present0 <= dec0.valid || (present0 && !pair_wr);
            present1 <= dec1.valid || (present1 && !pair_wr);
        end
    end

    assign pair_wr = present0 && present1;

    // Channel 1 in the upper half
    word_fifo u_word_fifo (
        .clk      (clk),
        .reset_b  (reset_b),
        .wr_en    (pair_wr),
        .wr_data  ({hold1, hold0}),
        .rd_en    (xfer),
        .rd_data  (fifo_rd_data),
        .empty    (fifo_empty),
        .overflow (overflow)
    );

    //////////////////////////////////////////////////
    // Frame FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        tvalid     = 1'b0;
        case (state)
            IDLE: begin
                if (!fifo_empty) begin
                    next_state = SEND;
                end
            end
            SEND: begin
                tvalid = !fifo_empty;
                if (tvalid && tready && last_beat) begin
                    next_state = IDLE;
                end else if (tvalid && !tready) begin
                    next_state = HOLD;
                end
            end
            HOLD: begin
                // Head word stays put since nothing is read
                tvalid = 1'b1;
                if (tready) begin
                    next_state = last_beat ? IDLE : SEND;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    assign xfer = tvalid && tready;

    // Beats within the current frame
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            beat_cnt <= '0;
        end else if (xfer) begin
            beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
        end
    end

    assign last_beat = (beat_cnt == FRAME_CNT_W'(FRAME_LEN - 1));

    assign stream.tvalid = tvalid;
    assign stream.tlast  = tvalid && last_beat;
    assign stream.tdata  = fifo_rd_data;

    assign frame_active = (state != IDLE);

endmodule

/* hw/sample_framer_top.sv */
`timescale 1ns/10ps

module sample_framer_top import framer_pkg::*; (
    input  logic    clk,
    input  logic    reset_b,
    input  sample_t ch0_in,
    input  sample_t ch1_in,
    input  logic    tready,
    output stream_t stream,
    output logic    frame_active,
    output logic    overflow
);

    // Decimated samples, one strobe per group of four
    sample_t dec0;
    sample_t dec1;

    //////////////////////////////////////////////////
    // Per-channel decimators
    //////////////////////////////////////////////////

    channel_decimator u_dec0 (
        .clk       (clk),
        .reset_b   (reset_b),
        .sample_in (ch0_in),
        .dec_out   (dec0)
    );

    channel_decimator u_dec1 (
        .clk       (clk),
        .reset_b   (reset_b),
        .sample_in (ch1_in),
        .dec_out   (dec1)
    );

    //////////////////////////////////////////////////
    // Pairing, buffering and stream output
    //////////////////////////////////////////////////

    frame_streamer u_frame_streamer (
        .clk          (clk),
        .reset_b      (reset_b),
        .dec0         (dec0),
        .dec1         (dec1),
        .tready       (tready),
        .stream       (stream),
        .frame_active (frame_active),
        .overflow     (overflow)
    );

endmodule

/* verification/tb_sample_framer.sv */
`timescale 1ns/10ps

module tb_sample_framer import framer_pkg::*; ();

    logic    clk;
    logic    reset_b;
    sample_t ch0_in;
    sample_t ch1_in;
    logic    tready;
    stream_t stream;
    logic    frame_active;
    logic    overflow;

    // Stimulus
    string               cur_test;
    logic [31:0]         lfsr_state;
    bit                  ready_random;
    logic [SAMPLE_W-1:0] src0 [$];
    logic [SAMPLE_W-1:0] src1 [$];

    // Reference model
    int                  grp0 [$];
    int                  grp1 [$];
    logic [SAMPLE_W-1:0] avg0 [$];
    logic [SAMPLE_W-1:0] avg1 [$];
    logic [WORD_W-1:0]   exp_words [$];
    int                  words_made;

    // Stream monitor
    int                  xfer_count;
    logic                stall_seen;
    logic [WORD_W-1:0]   stall_data;
    logic                stall_last;
    logic [WORD_W-1:0]   exp_word;
    logic                exp_last;

    sample_framer_top i_sample_framer_top (
        .clk          (clk),
        .reset_b      (reset_b),
        .ch0_in       (ch0_in),
        .ch1_in       (ch1_in),
        .tready       (tready),
        .stream       (stream),
        .frame_active (frame_active),
        .overflow     (overflow)
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // Random bits and reference model
    //////////////////////////////////////////////////

    // Galois LFSR with taps 32 22 2 1
    function automatic logic next_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [SAMPLE_W-1:0] random_sample();
        logic [SAMPLE_W-1:0] v;
        int                  i;
        v = '0;
        for (i = 0; i < SAMPLE_W; i++) begin
            v = {v[SAMPLE_W-2:0], next_bit()};
        end
        return v;
    endfunction

    // Mean of one group rounded toward minus infinity
    function automatic logic [SAMPLE_W-1:0] group_mean(input int g [$]);
        int total;
        int q;
        int i;
        total = 0;
        for (i = 0; i < g.size(); i++) begin
            total += g[i];
        end
        q = total / DECIM_FACTOR;
        if ((total % DECIM_FACTOR) != 0 && total < 0) begin
            q = q - 1;
        end
        return q[SAMPLE_W-1:0];
    endfunction

    function automatic void model_sample(input int ch, input logic [SAMPLE_W-1:0] value);
        int                  sval;
        logic [SAMPLE_W-1:0] lo;
        logic [SAMPLE_W-1:0] hi;
        sval = int'($signed(value));
        if (ch == 0) begin
            grp0.push_back(sval);
            if (grp0.size() == DECIM_FACTOR) begin
                avg0.push_back(group_mean(grp0));
                grp0.delete();
            end
        end else begin
            grp1.push_back(sval);
            if (grp1.size() == DECIM_FACTOR) begin
                avg1.push_back(group_mean(grp1));
                grp1.delete();
            end
        end
        // Pair in order with channel 1 on top
        while (avg0.size() > 0 && avg1.size() > 0) begin
            lo = avg0.pop_front();
            hi = avg1.pop_front();
            exp_words.push_back({hi, lo});
            words_made++;
        end
    endfunction

    //////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////

    task automatic abort_run(input string msg);
        streamer_state_t st;
        st = i_sample_framer_top.u_frame_streamer.state;
        $display("%s", msg);
        $display("frame FSM was in %s", st.name());
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        assert (actual === expected) else abort_run($sformatf(
            "FAILED %s: %s expected %b, actual %b", cur_test, what, expected, actual));
    endtask

    task automatic check_word(input string what, input logic [WORD_W-1:0] expected,
                              input logic [WORD_W-1:0] actual);
        assert (actual === expected) else abort_run($sformatf(
            "FAILED %s: %s expected %h, actual %h", cur_test, what, expected, actual));
    endtask

    // Values read at the falling edge hold for the next rising edge
    always @(negedge clk) begin
        if (reset_b) begin
            if (stall_seen) begin
                check_bit("tvalid during stall", 1'b1, stream.tvalid);
                check_word("tdata during stall", stall_data, stream.tdata);
                check_bit("tlast during stall", stall_last, stream.tlast);
            end
            if (stream.tvalid && tready) begin
                assert (exp_words.size() > 0) else abort_run($sformatf(
                    "%s: the DUT sent a word that was not expected", cur_test));
                exp_word = exp_words.pop_front();
                exp_last = (xfer_count % FRAME_LEN) == (FRAME_LEN - 1);
                check_word("tdata", exp_word, stream.tdata);
                check_bit("tlast", exp_last, stream.tlast);
                check_bit("frame_active during transfer", 1'b1, frame_active);
                xfer_count++;
            end
            stall_seen = stream.tvalid && !tready;
            stall_data = stream.tdata;
            stall_last = stream.tlast;
        end
    end

    //////////////////////////////////////////////////
    // Drive helpers
    //////////////////////////////////////////////////

    task automatic add_pair(input logic [SAMPLE_W-1:0] s0, input logic [SAMPLE_W-1:0] s1);
        src0.push_back(s0);
        src1.push_back(s1);
    endtask

    task automatic add_random_words(input int n_words);
        int i;
        for (i = 0; i < n_words * DECIM_FACTOR; i++) begin
            add_pair(random_sample(), random_sample());
        end
    endtask

    // Channel 1 starts lag cycles after channel 0
    task automatic drive_sources(input int lag);
        int total;
        int cyc;
        int k;
        total = src0.size() + lag;
        for (cyc = 0; cyc < total; cyc++) begin
            @(posedge clk);
            if (cyc < src0.size()) begin
                ch0_in <= {1'b1, src0[cyc]};
                model_sample(0, src0[cyc]);
            end else begin
                ch0_in <= '0;
            end
            k = cyc - lag;
            if (k >= 0 && k < src1.size()) begin
                ch1_in <= {1'b1, src1[k]};
                model_sample(1, src1[k]);
            end else begin
                ch1_in <= '0;
            end
            if (ready_random) begin
                tready <= next_bit();
            end
        end
        @(posedge clk);
        ch0_in <= '0;
        ch1_in <= '0;
        src0.delete();
        src1.delete();
    endtask

    task automatic wait_drained(input int limit);
        int cyc;
        cyc = 0;
        while (exp_words.size() > 0 && cyc < limit) begin
            @(posedge clk);
            if (ready_random) begin
                tready <= next_bit();
            end
            cyc++;
        end
        assert (exp_words.size() == 0) else abort_run($sformatf(
            "%s: timed out with %0d words never sent", cur_test, exp_words.size()));
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset();
        int cyc;
        cur_test = "test_reset";
        for (cyc = 0; cyc < 3; cyc++) begin
            @(negedge clk);
            check_bit("tvalid", 1'b0, stream.tvalid);
            check_bit("tlast", 1'b0, stream.tlast);
            check_bit("frame_active", 1'b0, frame_active);
            check_bit("overflow", 1'b0, overflow);
        end
        @(posedge clk);
        reset_b <= 1'b1;
        @(negedge clk);
        check_bit("tvalid", 1'b0, stream.tvalid);
        check_bit("tlast", 1'b0, stream.tlast);
        check_bit("frame_active", 1'b0, frame_active);
        check_bit("overflow", 1'b0, overflow);
    endtask

    task automatic test_average();
        cur_test = "test_average";
        @(posedge clk);
        tready <= 1'b1;
        // Negative sums off a multiple of four
        add_pair(-16'sd1, 16'sd1);
        add_pair(16'sd0, 16'sd1);
        add_pair(16'sd0, 16'sd1);
        add_pair(16'sd0, 16'sd0);
        add_pair(-16'sd5, 16'h7fff);
        add_pair(-16'sd2, 16'h7fff);
        add_pair(16'sd0, 16'h7fff);
        add_pair(16'sd0, 16'h7fff);
        // Full scale negative against a small mixed group
        add_pair(16'h8000, 16'sd5);
        add_pair(16'h8000, -16'sd6);
        add_pair(16'h8000, 16'sd2);
        add_pair(16'h8000, -16'sd3);
        add_pair(16'sd7, -16'sd4);
        add_pair(16'sd0, -16'sd4);
        add_pair(16'sd0, -16'sd4);
        add_pair(16'sd0, -16'sd3);
        drive_sources(0);
        wait_drained(200);
    endtask

    task automatic test_full_frame();
        int need;
        int cyc;
        cur_test = "test_full_frame";
        need = FRAME_LEN - (words_made % FRAME_LEN);
        add_random_words(need);
        drive_sources(0);
        wait_drained(need * 8 + 100);
        cyc = 0;
        while (frame_active && cyc < 20) begin
            @(negedge clk);
            cyc++;
        end
        check_bit("frame_active after frame", 1'b0, frame_active);
    endtask

    task automatic test_backpressure();
        cur_test = "test_backpressure";
        ready_random = 1'b1;
        add_random_words(12);
        drive_sources(0);
        wait_drained(1000);
        ready_random = 1'b0;
        @(posedge clk);
        tready <= 1'b1;
    endtask

    task automatic test_skew();
        cur_test = "test_skew";
        add_random_words(8);
        drive_sources(3);
        wait_drained(300);
    endtask

    task automatic test_overflow();
        int cyc;
        cur_test = "test_overflow";
        @(posedge clk);
        tready <= 1'b0;
        add_random_words(20);
        drive_sources(0);
        cyc = 0;
        while (!overflow && cyc < 100) begin
            @(negedge clk);
            cyc++;
        end
        check_bit("overflow", 1'b1, overflow);
        // Last pair reaches the FIFO two cycles after its decimator pulse
        repeat (4) @(posedge clk);
        while (exp_words.size() > FIFO_DEPTH) begin
            exp_words.delete(exp_words.size() - 1);
        end
        tready <= 1'b1;
        wait_drained(200);
        // Any extra word here is caught by the monitor
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_bit("overflow after drain", 1'b1, overflow);
    endtask

    initial begin
        clk          = 1'b0;
        reset_b      = 1'b0;
        ch0_in       = '0;
        ch1_in       = '0;
        tready       = 1'b0;
        lfsr_state   = 32'hbbc0b472;
        ready_random = 1'b0;
        words_made   = 0;
        xfer_count   = 0;
        stall_seen   = 1'b0;
        stall_data   = '0;
        stall_last   = 1'b0;

        test_reset();
        test_average();
        test_full_frame();
        test_backpressure();
        test_skew();
        test_overflow();

        $display("all tests passed");
        $finish;
    end

endmodule

/* filelist.f */
common/framer_pkg.sv
hw/channel_decimator.sv
hw/frame_streamer/word_fifo.sv
hw/frame_streamer/frame_streamer.sv
hw/sample_framer_top.sv
verification/tb_sample_framer.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the sample framer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_sample_framer -o tb_sample_framer
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sample_framer > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
